// ==== soc_pkg.sv ====
// System fabric shared definitions
`default_nettype none

package soc_pkg;

	localparam int GPIO_COUNT    = 16;
	localparam int INT_SRC_COUNT = 2;
	localparam int INT_SRC_GPIO  = 0;
	localparam int INT_SRC_EXT   = 1;

	// bits 15..12 pick the target, upper bits are don't care
	localparam int REGION_LSB = 12;
	localparam int REGION_MSB = 15;

	typedef logic [31:0]                data_t;
	typedef logic [31:0]                addr_t;
	typedef logic [3:0]                 sel_t;
	typedef logic [GPIO_COUNT-1:0]      gpio_t;
	typedef logic [INT_SRC_COUNT-1:0]   irq_vec_t;
	typedef logic [7:0]                 dev_id_t;
	typedef logic [REGION_LSB-3:0]      word_idx_t; // word offset inside a region

	localparam dev_id_t ID_RAM   = 8'd1;
	localparam dev_id_t ID_TABLE = 8'd7;
	localparam dev_id_t ID_GPIO  = 8'd6;
	localparam dev_id_t ID_INTC  = 8'd3;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		addr_t adr;
		data_t dat;
		sel_t  sel;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		data_t dat;
	} wb_rsp_t;

	typedef enum logic [2:0] {
		DEV_RAM,
		DEV_TABLE,
		DEV_GPIO,
		DEV_INTC,
		DEV_INVALID
	} dev_sel_t;

	function automatic dev_sel_t decode_dev(addr_t adr);
		case (adr[REGION_MSB:REGION_LSB])
			4'd0:    return DEV_RAM;
			4'd1:    return DEV_TABLE;
			4'd2:    return DEV_GPIO;
			4'd3:    return DEV_INTC;
			default: return DEV_INVALID;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== reset_seq.sv ====
// Fabric reset sequencer
`timescale 1ns/1ns
`default_nettype none

module reset_seq #(
	parameter int unsigned RST_CYCLES = 16
) (
	input  wire  clk100mhz,
	input  wire  rst_p,
	input  wire  warm_rst_req_i,
	output logic sys_rst_o,
	output logic ready_o
);

	localparam int CNT_W = $clog2(RST_CYCLES + 1);

	logic [CNT_W-1:0] cnt_q;

	assign sys_rst_o = (cnt_q != '0);

	always_ff @(posedge clk100mhz) begin
		if (rst_p || warm_rst_req_i) begin
			cnt_q   <= CNT_W'(RST_CYCLES - 1); // reload, ready comes back after RST_CYCLES
			ready_o <= 1'b0;
		end else begin
			if (sys_rst_o)
				cnt_q <= cnt_q - 1'b1;
			ready_o <= !sys_rst_o;
		end
	end

endmodule

`default_nettype wire

// ==== bus_arbiter.sv ====
// Two-master round-robin bus arbiter
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
	input  wire              clk100mhz,
	input  wire              rst_p,
	input  wire  soc_pkg::wb_req_t m0_req_i,
	input  wire  soc_pkg::wb_req_t m1_req_i,
	output soc_pkg::wb_rsp_t m0_rsp_o,
	output soc_pkg::wb_rsp_t m1_rsp_o,
	output soc_pkg::wb_req_t bus_req_o,
	input  wire  soc_pkg::wb_rsp_t bus_rsp_i
);

	logic [1:0] grant_q; // one-hot owner, zero when idle
	logic       last_m1_q;
	logic       m0_want;
	logic       m1_want;
	logic       owner_cyc;

	assign m0_want   = m0_req_i.cyc & m0_req_i.stb;
	assign m1_want   = m1_req_i.cyc & m1_req_i.stb;
	assign owner_cyc = |(grant_q & {m1_req_i.cyc, m0_req_i.cyc});

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			grant_q   <= 2'b00;
			last_m1_q <= 1'b1; // processor port goes first
		end else if (grant_q == 2'b00) begin
			if (m0_want && (!m1_want || last_m1_q))
				grant_q <= 2'b01;
			else if (m1_want)
				grant_q <= 2'b10;
		end else if (bus_rsp_i.ack || !owner_cyc) begin
			grant_q   <= 2'b00; // rearbitrate after every access
			last_m1_q <= grant_q[1];
		end
	end

	always_comb begin
		bus_req_o = '0;
		m0_rsp_o  = '0;
		m1_rsp_o  = '0;
		if (grant_q[0]) begin
			bus_req_o = m0_req_i;
			m0_rsp_o  = bus_rsp_i;
		end else if (grant_q[1]) begin
			bus_req_o = m1_req_i;
			m1_rsp_o  = bus_rsp_i;
		end
	end

endmodule

`default_nettype wire

// ==== bus_decoder.sv ====
// Address decoder and response mux
`timescale 1ns/1ns
`default_nettype none

module bus_decoder (
	input  wire  soc_pkg::wb_req_t bus_req_i,
	output soc_pkg::wb_rsp_t bus_rsp_o,
	output soc_pkg::wb_req_t ram_req_o,
	output soc_pkg::wb_req_t tbl_req_o,
	output soc_pkg::wb_req_t gpio_req_o,
	output soc_pkg::wb_req_t intc_req_o,
	input  wire  soc_pkg::wb_rsp_t ram_rsp_i,
	input  wire  soc_pkg::wb_rsp_t tbl_rsp_i,
	input  wire  soc_pkg::wb_rsp_t gpio_rsp_i,
	input  wire  soc_pkg::wb_rsp_t intc_rsp_i,
	input  wire  clk100mhz,
	input  wire  rst_p
);

	import soc_pkg::*;

	dev_sel_t dev;
	logic     inv_ack_q;

	assign dev = decode_dev(bus_req_i.adr);

	always_comb begin
		ram_req_o      = bus_req_i;
		tbl_req_o      = bus_req_i;
		gpio_req_o     = bus_req_i;
		intc_req_o     = bus_req_i;
		ram_req_o.stb  = bus_req_i.stb & (dev == DEV_RAM);
		tbl_req_o.stb  = bus_req_i.stb & (dev == DEV_TABLE);
		gpio_req_o.stb = bus_req_i.stb & (dev == DEV_GPIO);
		intc_req_o.stb = bus_req_i.stb & (dev == DEV_INTC);
	end

	// unmapped regions ack with zero data
	always_ff @(posedge clk100mhz) begin
		if (rst_p)
			inv_ack_q <= 1'b0;
		else
			inv_ack_q <= bus_req_i.cyc & bus_req_i.stb & (dev == DEV_INVALID) & !inv_ack_q;
	end

	always_comb begin
		case (dev)
			DEV_RAM:   bus_rsp_o = ram_rsp_i;
			DEV_TABLE: bus_rsp_o = tbl_rsp_i;
			DEV_GPIO:  bus_rsp_o = gpio_rsp_i;
			DEV_INTC:  bus_rsp_o = intc_rsp_i;
			default:   bus_rsp_o = '{ack: inv_ack_q, dat: '0};
		endcase
	end

endmodule

`default_nettype wire

// ==== dev_table.sv ====
// Device descriptor table
`timescale 1ns/1ns
`default_nettype none

module dev_table (
	input  wire  clk100mhz,
	input  wire  rst_p,
	input  wire  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o,
	output logic warm_rst_req_o
);

	import soc_pkg::*;

	word_idx_t idx;
	logic      acc;
	logic      ack_q;
	data_t     rd_dat;
	data_t     dat_q;

	assign idx = req_i.adr[REGION_LSB-1:2];
	assign acc = req_i.cyc & req_i.stb & !ack_q;

	// id in 7:0, uses-interrupt flag in bit 8
	always_comb begin
		case (idx)
			word_idx_t'(0): rd_dat = {23'b0, 1'b0, ID_RAM};
			word_idx_t'(1): rd_dat = {23'b0, 1'b0, ID_TABLE};
			word_idx_t'(2): rd_dat = {23'b0, 1'b1, ID_GPIO};
			word_idx_t'(3): rd_dat = {23'b0, 1'b0, ID_INTC};
			default:        rd_dat = '0; // word 4 is write-only control
		endcase
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			ack_q          <= 1'b0;
			warm_rst_req_o <= 1'b0;
		end else begin
			ack_q          <= acc;
			warm_rst_req_o <= acc & req_i.we & (idx == word_idx_t'(4)) &
				req_i.sel[0] & req_i.dat[0];
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (acc)
			dat_q <= rd_dat;
	end

	assign rsp_o = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// ==== gpio_port.sv ====
// GPIO port with change detect
`timescale 1ns/1ns
`default_nettype none

module gpio_port (
	input  wire  clk100mhz,
	input  wire  rst_p,
	input  wire  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o,
	input  wire  soc_pkg::gpio_t gpio_i,
	output soc_pkg::gpio_t gpio_o,
	output logic change_o
);

	import soc_pkg::*;

	word_idx_t idx;
	logic      acc;
	logic      ack_q;
	gpio_t     sync1_q;
	gpio_t     sync2_q;
	gpio_t     prev_q;
	data_t     dat_q;

	assign idx = req_i.adr[REGION_LSB-1:2];
	assign acc = req_i.cyc & req_i.stb & !ack_q;

	// two-stage input synchronizer
	always_ff @(posedge clk100mhz) begin
		sync1_q <= gpio_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			ack_q    <= 1'b0;
			change_o <= 1'b0;
			gpio_o   <= '0;
		end else begin
			ack_q    <= acc;
			change_o <= (sync2_q != prev_q);
			if (acc && req_i.we && idx == word_idx_t'(1)) begin
				for (int b = 0; b < GPIO_COUNT / 8; b++)
					if (req_i.sel[b])
						gpio_o[b*8 +: 8] <= req_i.dat[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (acc) begin
			case (idx)
				word_idx_t'(0): dat_q <= data_t'(sync2_q);
				word_idx_t'(1): dat_q <= data_t'(gpio_o);
				default:        dat_q <= '0;
			endcase
		end
	end

	assign rsp_o = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// ==== int_ctrl.sv ====
// Interrupt pending and enable registers
`timescale 1ns/1ns
`default_nettype none

module int_ctrl (
	input  wire  clk100mhz,
	input  wire  rst_p,
	input  wire  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o,
	input  wire  soc_pkg::irq_vec_t src_i,
	output logic irq_o
);

	import soc_pkg::*;

	word_idx_t idx;
	logic      acc;
	logic      ack_q;
	irq_vec_t  src_q;
	irq_vec_t  rise;
	irq_vec_t  clr;
	irq_vec_t  pend_q;
	irq_vec_t  en_q;
	data_t     dat_q;

	assign idx  = req_i.adr[REGION_LSB-1:2];
	assign acc  = req_i.cyc & req_i.stb & !ack_q;
	assign rise = src_i & ~src_q;
	assign clr  = (acc && req_i.we && req_i.sel[0] && idx == word_idx_t'(0)) ?
		req_i.dat[INT_SRC_COUNT-1:0] : '0; // write 1 to clear

	always_ff @(posedge clk100mhz) begin
		src_q <= src_i;
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			ack_q  <= 1'b0;
			pend_q <= '0;
			en_q   <= '0;
		end else begin
			ack_q  <= acc;
			pend_q <= (pend_q & ~clr) | rise; // new edge wins over clear
			if (acc && req_i.we && req_i.sel[0] && idx == word_idx_t'(1))
				en_q <= req_i.dat[INT_SRC_COUNT-1:0];
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (acc) begin
			case (idx)
				word_idx_t'(0): dat_q <= data_t'(pend_q);
				word_idx_t'(1): dat_q <= data_t'(en_q);
				default:        dat_q <= '0;
			endcase
		end
	end

	assign irq_o = |(pend_q & en_q);
	assign rsp_o = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// ==== ram_block.sv ====
// On-chip RAM with byte lanes
`timescale 1ns/1ns
`default_nettype none

module ram_block #(
	parameter int unsigned RAM_WORDS = 1024
) (
	input  wire  clk100mhz,
	input  wire  rst_p,
	input  wire  soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o
);

	import soc_pkg::*;

	localparam int AW = $clog2(RAM_WORDS);

	data_t         mem [RAM_WORDS];
	data_t         dat_q;
	logic [AW-1:0] idx;
	logic          acc;
	logic          ack_q;

	assign idx = req_i.adr[2 +: AW]; // upper region bits alias
	assign acc = req_i.cyc & req_i.stb & !ack_q;

	always_ff @(posedge clk100mhz) begin
		if (rst_p)
			ack_q <= 1'b0;
		else
			ack_q <= acc;
	end

	always_ff @(posedge clk100mhz) begin
		if (acc) begin
			dat_q <= mem[idx];
			if (req_i.we) begin
				for (int b = 0; b < 4; b++)
					if (req_i.sel[b])
						mem[idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
			end
		end
	end

	assign rsp_o = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// ==== soc_top.sv ====
// System fabric top level
`timescale 1ns/1ns
`default_nettype none

module soc_top #(
	parameter int unsigned RST_CYCLES = 16,
	parameter int unsigned RAM_WORDS  = 1024
) (
	input  wire  clk100mhz,
	input  wire  rst_p,
	input  wire  soc_pkg::wb_req_t m0_req_i,
	input  wire  soc_pkg::wb_req_t m1_req_i,
	output soc_pkg::wb_rsp_t m0_rsp_o,
	output soc_pkg::wb_rsp_t m1_rsp_o,
	input  wire  soc_pkg::gpio_t gpio_i,
	output soc_pkg::gpio_t gpio_o,
	input  wire  ext_irq_i,
	output logic irq_o,
	output logic ready_o
);

	import soc_pkg::*;

	logic     sys_rst;
	logic     warm_rst_req;
	logic     gpio_change;
	irq_vec_t irq_src;
	wb_req_t  bus_req;
	wb_rsp_t  bus_rsp;
	wb_req_t  ram_req, tbl_req, gpio_req, intc_req;
	wb_rsp_t  ram_rsp, tbl_rsp, gpio_rsp, intc_rsp;

	assign irq_src[INT_SRC_GPIO] = gpio_change;
	assign irq_src[INT_SRC_EXT]  = ext_irq_i;

	reset_seq #(.RST_CYCLES(RST_CYCLES)) i_reset_seq (
		.clk100mhz(clk100mhz), .rst_p(rst_p), .warm_rst_req_i(warm_rst_req),
		.sys_rst_o(sys_rst), .ready_o(ready_o)
	);

	bus_arbiter i_bus_arbiter (
		.clk100mhz(clk100mhz), .rst_p(sys_rst),
		.m0_req_i(m0_req_i), .m1_req_i(m1_req_i),
		.m0_rsp_o(m0_rsp_o), .m1_rsp_o(m1_rsp_o),
		.bus_req_o(bus_req), .bus_rsp_i(bus_rsp)
	);

	bus_decoder i_bus_decoder (
		.bus_req_i(bus_req), .bus_rsp_o(bus_rsp),
		.ram_req_o(ram_req), .tbl_req_o(tbl_req),
		.gpio_req_o(gpio_req), .intc_req_o(intc_req),
		.ram_rsp_i(ram_rsp), .tbl_rsp_i(tbl_rsp),
		.gpio_rsp_i(gpio_rsp), .intc_rsp_i(intc_rsp),
		.clk100mhz(clk100mhz), .rst_p(sys_rst)
	);

	ram_block #(.RAM_WORDS(RAM_WORDS)) i_ram_block (
		.clk100mhz(clk100mhz), .rst_p(sys_rst), .req_i(ram_req), .rsp_o(ram_rsp)
	);

	dev_table i_dev_table (
		.clk100mhz(clk100mhz), .rst_p(sys_rst), .req_i(tbl_req), .rsp_o(tbl_rsp),
		.warm_rst_req_o(warm_rst_req)
	);

	gpio_port i_gpio_port (
		.clk100mhz(clk100mhz), .rst_p(sys_rst), .req_i(gpio_req), .rsp_o(gpio_rsp),
		.gpio_i(gpio_i), .gpio_o(gpio_o), .change_o(gpio_change)
	);

	int_ctrl i_int_ctrl (
		.clk100mhz(clk100mhz), .rst_p(sys_rst), .req_i(intc_req), .rsp_o(intc_rsp),
		.src_i(irq_src), .irq_o(irq_o)
	);

endmodule

`default_nettype wire

// ==== tb_bus_tasks.svh ====
// Testbench bus access tasks
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_eq(input string name, input data_t got, input data_t exp);
		check_count++;
		assert (got === exp) else begin
			err_count++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic drive_request(input int port, input wb_req_t req);
		if (port == 0)
			m0_req = req;
		else
			m1_req = req;
	endtask

	function automatic wb_rsp_t port_response(input int port);
		return (port == 0) ? m0_rsp : m1_rsp;
	endfunction

	// one classic cycle, request held until ack
	task automatic bus_access(input int port, input logic we, input addr_t adr,
		input data_t wdat, input sel_t sel, output data_t rdat);
		wb_req_t req;
		wb_rsp_t rsp;
		int      waited;
		logic    acked;
		req    = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: sel};
		rdat   = '0;
		waited = 0;
		acked  = 1'b0;
		drive_request(port, req);
		while (!acked && waited < ACK_TIMEOUT) begin
			@(negedge clk100mhz); // ack is stable mid-cycle
			rsp = port_response(port);
			if (rsp.ack === 1'b1) begin
				acked = 1'b1;
				rdat  = rsp.dat;
			end
			waited++;
		end
		@(posedge clk100mhz);
		#1;
		if (acked) begin
			done_log.push_back(port);
			rsp = port_response(port);
			check_eq($sformatf("m%0d_rsp_o.ack after completion", port), rsp.ack, 1'b0);
		end else begin
			timeout_count++;
			$display("port %0d got no ack for the access to %h at %0t", port, adr, $time);
		end
		drive_request(port, '0);
	endtask

	task automatic bus_write(input int port, input addr_t adr, input data_t dat,
		input sel_t sel);
		data_t unused;
		bus_access(port, 1'b1, adr, dat, sel, unused);
	endtask

	task automatic bus_read(input int port, input addr_t adr, output data_t dat);
		bus_access(port, 1'b0, adr, '0, 4'hf, dat);
	endtask

	task automatic count_until_ready(output int cycles);
		cycles = 0;
		while (ready !== 1'b1 && cycles < 4 * RST_CYCLES) begin
			@(posedge clk100mhz);
			#1;
			cycles++;
		end
		if (ready !== 1'b1) begin
			timeout_count++;
			$display("ready_o stayed low for %0d cycles", cycles);
		end
	endtask

`endif

// ==== tb_soc.sv ====
// System fabric testbench
`timescale 1ns/1ns
`default_nettype none

module tb_soc;

	import soc_pkg::*;

	localparam int RST_CYCLES  = 16;
	localparam int RAM_WORDS   = 256;
	localparam int ACK_TIMEOUT = 40;
	localparam int TEST_WORDS  = 16;

	localparam addr_t TBL_BASE  = addr_t'(1) << REGION_LSB;
	localparam addr_t GPIO_BASE = addr_t'(2) << REGION_LSB;
	localparam addr_t INTC_BASE = addr_t'(3) << REGION_LSB;

	logic        clk100mhz;
	logic        rst_p;
	wb_req_t     m0_req;
	wb_req_t     m1_req;
	wb_rsp_t     m0_rsp;
	wb_rsp_t     m1_rsp;
	gpio_t       gpio_in;
	gpio_t       gpio_out;
	logic        ext_irq;
	logic        irq;
	logic        ready;
	int          err_count;
	int          timeout_count;
	int          check_count;
	int          done_log[$];
	data_t       ram_model [RAM_WORDS];
	data_t       traffic [16];
	logic [31:0] lcg_state;

	`include "tb_bus_tasks.svh"

	soc_top #(.RST_CYCLES(RST_CYCLES), .RAM_WORDS(RAM_WORDS)) i_dut (
		.clk100mhz(clk100mhz), .rst_p(rst_p),
		.m0_req_i(m0_req), .m1_req_i(m1_req), .m0_rsp_o(m0_rsp), .m1_rsp_o(m1_rsp),
		.gpio_i(gpio_in), .gpio_o(gpio_out), .ext_irq_i(ext_irq), .irq_o(irq),
		.ready_o(ready)
	);

	initial begin
		clk100mhz = 1'b0;
		forever #5 clk100mhz = ~clk100mhz;
	end

	function automatic addr_t ram_addr(input int w);
		return addr_t'(w) << 2;
	endfunction

	function automatic data_t merge_bytes(input data_t old, input data_t nw, input sel_t sel);
		data_t res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (sel[b])
				res[b*8 +: 8] = nw[b*8 +: 8];
		return res;
	endfunction

	function automatic data_t table_entry(input int w);
		case (w)
			0:       return data_t'(ID_RAM);
			1:       return data_t'(ID_TABLE);
			2:       return data_t'(ID_GPIO) | 32'h100; // only gpio flags an interrupt
			3:       return data_t'(ID_INTC);
			default: return '0;
		endcase
	endfunction

	task automatic check_ram(input int words);
		data_t rd;
		for (int w = 0; w < words; w++) begin
			bus_read(w % 2, ram_addr(w), rd);
			check_eq($sformatf("ram word %0d", w), rd, ram_model[w]);
		end
	endtask

	task automatic port_traffic(input int port, input int base);
		data_t rd;
		for (int k = 0; k < 8; k++) begin
			bus_write(port, ram_addr(base + k), traffic[port*8 + k], 4'hf);
			ram_model[base + k] = traffic[port*8 + k];
			bus_read(port, ram_addr(base + k), rd);
			check_eq($sformatf("m%0d read word %0d", port, base + k), rd, ram_model[base + k]);
		end
	endtask

	initial begin
		data_t rd;
		data_t wd;
		data_t v;
		int    n;
		int    w;
		rst_p         = 1'b1;
		m0_req        = '0;
		m1_req        = '0;
		gpio_in       = '0;
		ext_irq       = 1'b0;
		err_count     = 0;
		timeout_count = 0;
		check_count   = 0;
		lcg_state     = 32'h7cdce52b;

		for (int i = 0; i < RST_CYCLES; i++) begin
			@(posedge clk100mhz);
			#1;
			if (i >= 2) begin // sequencer loaded by now
				check_eq("ready_o", ready, 1'b0);
				check_eq("irq_o", irq, 1'b0);
				check_eq("gpio_o", gpio_out, '0);
			end
		end
		rst_p = 1'b0;
		count_until_ready(n);
		check_eq("ready_o delay", n, RST_CYCLES);
		check_eq("irq_o", irq, 1'b0);
		check_eq("gpio_o", gpio_out, '0);
		check_eq("m0_rsp_o.ack", m0_rsp.ack, 1'b0);
		check_eq("m1_rsp_o.ack", m1_rsp.ack, 1'b0);

		// ram with byte lanes from both ports
		for (w = 0; w < TEST_WORDS; w++) begin
			wd = lcg_next();
			bus_write(w % 2, ram_addr(w), wd, 4'hf);
			ram_model[w] = wd;
		end
		for (int k = 0; k < 48; k++) begin
			v  = lcg_next();
			wd = lcg_next();
			w  = v[3:0];
			bus_write(v[8], ram_addr(w), wd, v[7:4]);
			ram_model[w] = merge_bytes(ram_model[w], wd, v[7:4]);
		end
		check_ram(TEST_WORDS);
		bus_read(1, ram_addr(5) | 32'h5a5a_0c00, rd); // upper bits alias
		check_eq("ram alias read", rd, ram_model[5]);

		// device table and unmapped regions
		for (w = 0; w < 4; w++) begin
			bus_read(w % 2, TBL_BASE + 4 * w, rd);
			check_eq($sformatf("table word %0d", w), rd, table_entry(w));
			bus_write(1 - w % 2, TBL_BASE + 4 * w, 32'hffff_ffff, 4'hf);
			bus_read(w % 2, TBL_BASE + 4 * w, rd);
			check_eq($sformatf("table word %0d after write", w), rd, table_entry(w));
		end
		for (w = 5; w < 12; w++) begin
			bus_read(w % 2, TBL_BASE + 4 * w, rd);
			check_eq($sformatf("table word %0d", w), rd, '0);
		end
		for (int r = 4; r < 16; r++) begin
			v = lcg_next();
			bus_read(r % 2, {v[31:16], 4'(r), v[11:0]}, rd);
			check_eq($sformatf("region %0d read", r), rd, '0);
			bus_write(1 - r % 2, (addr_t'(r) << REGION_LSB) + ram_addr(r - 4), v, 4'hf);
		end
		check_ram(TEST_WORDS);

		// gpio and interrupts
		bus_write(0, GPIO_BASE + 4, 32'h0000_a5c3, 4'hf);
		check_eq("gpio_o", gpio_out, 16'ha5c3);
		bus_read(1, GPIO_BASE + 4, rd);
		check_eq("gpio output register", rd, 32'h0000_a5c3);
		bus_write(1, INTC_BASE + 4, 32'h1, 4'hf);
		bus_read(0, INTC_BASE, rd);
		check_eq("pending", rd, '0);
		check_eq("irq_o", irq, 1'b0);
		gpio_in = 16'h1234;
		n = 0;
		while (irq !== 1'b1 && n < 20) begin
			@(posedge clk100mhz);
			#1;
			n++;
		end
		if (irq !== 1'b1) begin
			timeout_count++;
			$display("irq_o did not rise after the gpio_i change");
		end
		bus_read(0, GPIO_BASE, rd);
		check_eq("gpio input word", rd, 32'h0000_1234);
		bus_read(1, INTC_BASE, rd);
		check_eq("pending", rd, 32'h1);
		bus_write(0, INTC_BASE, 32'h1, 4'hf);
		check_eq("irq_o after clear", irq, 1'b0);
		ext_irq = 1'b1;
		bus_read(1, INTC_BASE, rd);
		check_eq("pending", rd, 32'h2);
		check_eq("irq_o with ext masked", irq, 1'b0);
		ext_irq = 1'b0;
		bus_write(0, INTC_BASE + 4, 32'h3, 4'hf);
		check_eq("irq_o with ext enabled", irq, 1'b1);
		bus_write(1, INTC_BASE, 32'h2, 4'hf);
		check_eq("irq_o after ext clear", irq, 1'b0);

		// both ports contend on every access
		for (int k = 0; k < 16; k++)
			traffic[k] = lcg_next();
		done_log.delete();
		fork
			port_traffic(0, 32);
			port_traffic(1, 48);
		join
		check_eq("arbitrated access count", done_log.size(), 32);
		for (int i = 1; i < done_log.size(); i++) begin
			assert (done_log[i] != done_log[i-1]) else begin
				err_count++;
				$display("port %0d completed two accesses in a row, access %0d", done_log[i], i);
			end
		end

		// warm reset through table word 4
		bus_write(0, TBL_BASE + 16, 32'h1, 4'hf);
		check_eq("ready_o after warm reset request", ready, 1'b0);
		count_until_ready(n);
		check_eq("warm reset ready_o delay", n, RST_CYCLES);
		check_eq("gpio_o after warm reset", gpio_out, '0);
		check_eq("irq_o after warm reset", irq, 1'b0);
		bus_read(1, INTC_BASE + 4, rd);
		check_eq("enable after warm reset", rd, '0);
		check_ram(TEST_WORDS);

		$display("checks %0d, value errors %0d, timeouts %0d", check_count, err_count,
			timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
soc_pkg.sv
reset_seq.sv
bus_arbiter.sv
bus_decoder.sv
dev_table.sv
gpio_port.sv
int_ctrl.sv
ram_block.sv
soc_top.sv
tb_soc.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - soc_pkg.sv
  - reset_seq.sv
  - bus_arbiter.sv
  - bus_decoder.sv
  - dev_table.sv
  - gpio_port.sv
  - int_ctrl.sv
  - ram_block.sv
  - soc_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_soc.sv
